// ==== Makefile ====
# Verilator flow for the sigma tile testbench

TOP  = tb_sigma_tile
MDIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir $(MDIR)
	./$(MDIR)/V$(TOP) | tee sim.log
	@if grep -q "Errors found" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "No errors" sim.log

clean:
	rm -rf $(MDIR) sim.log

// ==== compile.f ====
+incdir+logic
+incdir+testbench
logic/tile_bus_pkg.sv
logic/tile_irq_pkg.sv
logic/tile_ram.sv
logic/irq_adapter.sv
logic/tile_sfr.sv
logic/host_router.sv
logic/sigma_tile.sv
testbench/tb_sigma_tile.sv

// ==== logic/host_router.sv ====
// host request router splitting RAM and SFR accesses and merging their responses
`include "tile_settings.svh"

module host_router import tile_bus_pkg::*;
(
    input  logic         clk_i
    , input  logic       arst_n_i
    , input  host_req_t  host_req_i
    , output host_resp_t host_resp_o
    , output host_req_t  ram_req_o
    , output host_req_t  sfr_req_o
    , input  host_resp_t ram_resp_i
    , input  host_resp_t sfr_resp_i
);

    logic sel_sfr;
    logic rd_pend_q;
    logic rd_sfr_q;

    assign sel_sfr = host_req_i.addr[`TILE_SFR_BITSEL];

    always_comb
    begin
        ram_req_o     = host_req_i;
        sfr_req_o     = host_req_i;
        ram_req_o.req = host_req_i.req && !sel_sfr;
        sfr_req_o.req = host_req_i.req && sel_sfr;
    end

    // only the valid side contributes data
    assign host_resp_o.resp  = ram_resp_i.resp | sfr_resp_i.resp;
    assign host_resp_o.rdata = ({32{ram_resp_i.resp}} & ram_resp_i.rdata)
                             | ({32{sfr_resp_i.resp}} & sfr_resp_i.rdata);

    // which target owes a response this cycle
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            rd_pend_q <= 1'b0;
            rd_sfr_q  <= 1'b0;
        end
        else
        begin
            rd_pend_q <= host_req_i.req && !host_req_i.we;
            rd_sfr_q  <= sel_sfr;
        end
    end

    a_resp_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(ram_resp_i.resp && sfr_resp_i.resp));

    // the addressed target, and only it, answers one cycle after a read
    a_resp_from_target: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        {sfr_resp_i.resp, ram_resp_i.resp}
            == {rd_pend_q && rd_sfr_q, rd_pend_q && !rd_sfr_q});

endmodule

// ==== logic/irq_adapter.sv ====
// interrupt adapter turning line edges and SGI into one prioritized request with code
module irq_adapter import tile_bus_pkg::*, tile_irq_pkg::*;
(
    input  logic        clk_i
    , input  logic      arst_n_i
    , input  logic      soft_rst_i
    , input  irq_vec_t  irq_lines_i
    , input  logic      sgi_req_i
    , input  irq_code_t sgi_code_i
    , input  logic      irq_ack_i
    , output logic      irq_req_o
    , output irq_code_t irq_code_o
);

    localparam int IRQ_NUM = $bits(irq_vec_t);

    irq_vec_t  lines_q;
    irq_vec_t  pending_q;
    irq_vec_t  pending_nxt;
    irq_vec_t  rise;
    irq_vec_t  sgi_vec;
    irq_vec_t  ack_vec;
    logic      req_q;
    irq_code_t code_q;

    // lowest set index wins
    function automatic irq_code_t lowest_idx(irq_vec_t v);
        irq_code_t idx;
        idx = '0;
        for (int i = IRQ_NUM - 1; i >= 0; i--)
        begin
            if (v[i])
            begin
                idx = irq_code_t'(i);
            end
        end
        return idx;
    endfunction

    assign rise    = irq_lines_i & ~lines_q;
    assign sgi_vec = sgi_req_i ? (irq_vec_t'(1) << sgi_code_i) : '0;
    assign ack_vec = (irq_ack_i && req_q) ? (irq_vec_t'(1) << code_q) : '0;

    // a fresh edge beats an ack on the same line
    assign pending_nxt = (pending_q & ~ack_vec) | rise | sgi_vec;

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            lines_q   <= '0;
            pending_q <= '0;
            req_q     <= 1'b0;
            code_q    <= '0;
        end
        else if (soft_rst_i)
        begin
            lines_q   <= '0;
            pending_q <= '0;
            req_q     <= 1'b0;
            code_q    <= '0;
        end
        else
        begin
            lines_q   <= irq_lines_i;
            pending_q <= pending_nxt;
            req_q     <= |pending_nxt;
            code_q    <= lowest_idx(pending_nxt);
        end
    end

    assign irq_req_o  = req_q;
    assign irq_code_o = code_q;

    // acks from outside only for a live request
    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        irq_ack_i |-> irq_req_o);

endmodule

// ==== logic/sigma_tile.sv ====
// memory and interrupt tile joining host router, data RAM and SFR block
module sigma_tile import tile_bus_pkg::*, tile_irq_pkg::*;
#(
    parameter int CORENUM = 0
)
(
    input  logic         clk_i
    , input  logic       arst_n_i
    , input  host_req_t  host_req_i
    , output host_resp_t host_resp_o
    , input  irq_vec_t   irq_i
    , input  logic       irq_ack_i
    , output logic       irq_req_o
    , output irq_code_t  irq_code_o
);

    host_req_t  ram_req;
    host_req_t  sfr_req;
    host_resp_t ram_resp;
    host_resp_t sfr_resp;

    host_router router (
        .clk_i        (clk_i)
        , .arst_n_i   (arst_n_i)
        , .host_req_i (host_req_i)
        , .host_resp_o(host_resp_o)
        , .ram_req_o  (ram_req)
        , .sfr_req_o  (sfr_req)
        , .ram_resp_i (ram_resp)
        , .sfr_resp_i (sfr_resp)
    );

    tile_ram ram (
        .clk_i   (clk_i)
        , .req_i (ram_req)
        , .resp_o(ram_resp)
    );

    tile_sfr #(
        .CORENUM(CORENUM)
    ) sfr (
        .clk_i       (clk_i)
        , .arst_n_i  (arst_n_i)
        , .req_i     (sfr_req)
        , .resp_o    (sfr_resp)
        , .irq_i     (irq_i)
        , .irq_ack_i (irq_ack_i)
        , .irq_req_o (irq_req_o)
        , .irq_code_o(irq_code_o)
    );

endmodule

// ==== logic/tile_bus_pkg.sv ====
// host bus package with word, address and byte-enable types and request/response structs
package tile_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  be_t;

    // one-cycle strobe request without back-pressure
    typedef struct packed {
        logic  req;
        logic  we;
        addr_t addr;
        be_t   be;
        word_t wdata;
    } host_req_t;

    // read response with strobe and data
    typedef struct packed {
        logic  resp;
        word_t rdata;
    } host_resp_t;

endpackage

// ==== logic/tile_irq_pkg.sv ====
// interrupt package with line vector, code and SFR register index types
`include "tile_settings.svh"

package tile_irq_pkg;

    // one bit per interrupt line
    typedef logic [(2**`TILE_IRQ_NUM_POW)-1:0] irq_vec_t;
    typedef logic [`TILE_IRQ_NUM_POW-1:0]      irq_code_t;

    // word offsets inside the SFR window
    typedef enum logic [2:0] {
        SFR_ID           = 3'd0,
        SFR_CTRL         = 3'd1,
        SFR_IRQ_EN       = 3'd2,
        SFR_SGI          = 3'd3,
        SFR_TIMER_PERIOD = 3'd4,
        SFR_TIMER_CTRL   = 3'd5
    } sfr_reg_e;

endpackage

// ==== logic/tile_ram.sv ====
// single-port tile data RAM with byte-enable writes and one-cycle reads
`include "tile_settings.svh"

module tile_ram import tile_bus_pkg::*;
(
    input  logic         clk_i
    , input  host_req_t  req_i
    , output host_resp_t resp_o
);

    localparam int AW = $clog2(`TILE_MEM_WORDS);

    word_t         mem [`TILE_MEM_WORDS];
    logic [AW-1:0] widx;
    logic          rd_en;
    logic          resp_q;
    word_t         rdata_q;

    // word index wraps at the RAM depth
    assign widx  = req_i.addr[AW+1:2];
    assign rd_en = req_i.req && !req_i.we;

    always_ff @(posedge clk_i)
    begin
        if (req_i.req && req_i.we)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (req_i.be[b])
                begin
                    mem[widx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        resp_q <= rd_en;
        if (rd_en)
        begin
            rdata_q <= mem[widx];
        end
    end

    assign resp_o.resp  = resp_q;
    assign resp_o.rdata = rdata_q;

endmodule

// ==== logic/tile_settings.svh ====
// tile build settings for address decode, RAM depth, interrupt lines and timer
`ifndef TILE_SETTINGS_SVH
`define TILE_SETTINGS_SVH

// address bit that selects the SFR block over RAM
`define TILE_SFR_BITSEL 20

// RAM depth in 32-bit words
`define TILE_MEM_WORDS 1024

// log2 of the interrupt line count
`define TILE_IRQ_NUM_POW 4

// timer counter width
`define TILE_TIMER_W 32

// software reset bit after hard reset
`define TILE_SW_RESET_DEFAULT 1'b0

`endif

// ==== logic/tile_sfr.sv ====
// special-function register block with core id, soft reset, irq mask, SGI and timer
`include "tile_settings.svh"

module tile_sfr import tile_bus_pkg::*, tile_irq_pkg::*;
#(
    parameter int CORENUM = 0
)
(
    input  logic         clk_i
    , input  logic       arst_n_i
    , input  host_req_t  req_i
    , output host_resp_t resp_o
    , input  irq_vec_t   irq_i
    , input  logic       irq_ack_i
    , output logic       irq_req_o
    , output irq_code_t  irq_code_o
);

    typedef logic [`TILE_TIMER_W-1:0] tmr_t;

    sfr_reg_e  reg_sel;
    logic      wr_en;
    logic      rd_en;
    logic      soft_rst_q;
    irq_vec_t  irq_en_q;
    tmr_t      period_q;
    tmr_t      cnt_q;
    logic      tmr_en_q;
    logic      tick_q;
    logic      sgi_req;
    irq_code_t sgi_code;
    irq_vec_t  irq_lines;
    word_t     rd_word;
    word_t     rdata_q;
    logic      resp_q;

    assign reg_sel = sfr_reg_e'(req_i.addr[4:2]);
    assign wr_en   = req_i.req && req_i.we;
    assign rd_en   = req_i.req && !req_i.we;

    // SGI fires in the write cycle itself
    assign sgi_req  = wr_en && (reg_sel == SFR_SGI);
    assign sgi_code = irq_code_t'(req_i.wdata);

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            soft_rst_q <= `TILE_SW_RESET_DEFAULT;
            irq_en_q   <= '0;
            period_q   <= '0;
            tmr_en_q   <= 1'b0;
        end
        else if (wr_en)
        begin
            case (reg_sel)
                SFR_CTRL:         soft_rst_q <= req_i.wdata[0];
                SFR_IRQ_EN:       irq_en_q   <= irq_vec_t'(req_i.wdata);
                SFR_TIMER_PERIOD: period_q   <= tmr_t'(req_i.wdata);
                SFR_TIMER_CTRL:   tmr_en_q   <= req_i.wdata[0];
                default:          ;
            endcase
        end
    end

    // counts 0..period and ticks once per wrap
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            cnt_q  <= '0;
            tick_q <= 1'b0;
        end
        else if (!tmr_en_q)
        begin
            cnt_q  <= '0;
            tick_q <= 1'b0;
        end
        else if (cnt_q == period_q)
        begin
            cnt_q  <= '0;
            tick_q <= 1'b1;
        end
        else
        begin
            cnt_q  <= cnt_q + 1'b1;
            tick_q <= 1'b0;
        end
    end

    always_comb
    begin
        case (reg_sel)
            SFR_ID:           rd_word = word_t'(CORENUM);
            SFR_CTRL:         rd_word = word_t'(soft_rst_q);
            SFR_IRQ_EN:       rd_word = word_t'(irq_en_q);
            SFR_TIMER_PERIOD: rd_word = word_t'(period_q);
            SFR_TIMER_CTRL:   rd_word = word_t'(tmr_en_q);
            default:          rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            resp_q <= 1'b0;
        end
        else
        begin
            resp_q <= rd_en;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rd_en)
        begin
            rdata_q <= rd_word;
        end
    end

    assign resp_o.resp  = resp_q;
    assign resp_o.rdata = rdata_q;

    // timer drives line 1
    assign irq_lines = (irq_i | (irq_vec_t'(tick_q) << 1)) & irq_en_q;

    irq_adapter irq_adapter (
        .clk_i        (clk_i)
        , .arst_n_i   (arst_n_i)
        , .soft_rst_i (soft_rst_q)
        , .irq_lines_i(irq_lines)
        , .sgi_req_i  (sgi_req)
        , .sgi_code_i (sgi_code)
        , .irq_ack_i  (irq_ack_i)
        , .irq_req_o  (irq_req_o)
        , .irq_code_o (irq_code_o)
    );

endmodule

// ==== testbench/tb_tile_tasks.svh ====
// checking, table building and host bus tasks for the sigma tile testbench
`ifndef TB_TILE_TASKS_SVH
`define TB_TILE_TASKS_SVH

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
        $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
        errors++;
    end
endtask

function void push_row(op_e op, logic [2:0] tst, addr_t a, word_t d, be_t be,
                       word_t e, word_t e2);
    row_t r;
    r = '{op: op, tst: tst, addr: a, data: d, be: be, exp: e, exp2: e2};
    rows.push_back(r);
endfunction

function automatic word_t mword(addr_t a);
    return ram_model[a[11:2]];
endfunction

// RAM model keeps the old bytes where the enable is low
function void record_write(logic [2:0] tst, addr_t a, word_t d, be_t be);
    push_row(OP_WR, tst, a, d, be, 0, 0);
    if (!a[20])
    begin
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
            begin
                ram_model[a[11:2]][b*8 +: 8] = d[b*8 +: 8];
            end
        end
    end
endfunction

function void expect_read(logic [2:0] tst, addr_t a, word_t e);
    push_row(OP_RD, tst, a, 0, 0, e, 0);
endfunction

function void expect_pair(logic [2:0] tst, addr_t a, word_t ea, addr_t b, word_t eb);
    push_row(OP_RD2, tst, a, b, 0, ea, eb);
endfunction

function automatic string test_name(logic [2:0] t);
    case (t)
        1: return "ram byte-enable access";
        2: return "sfr access";
        3: return "external irq mask and priority";
        4: return "software interrupt";
        5: return "timer interrupt";
        6: return "software reset";
        default: return "unknown";
    endcase
endfunction

task automatic report_test(input logic [2:0] t, input int errs);
    $display("test %0d %s: %s (%0d errors)", t, test_name(t), errs == 0 ? "ok" : "bad", errs);
endtask

task automatic drive_req(input logic we, input addr_t a, input word_t d, input be_t be);
    host_req <= '{req: 1'b1, we: we, addr: a, be: be, wdata: d};
endtask

task automatic wait_irq(input int max_cycles, input word_t code);
    int n;
    n = 0;
    @(negedge clk);
    while (!irq_req && n < max_cycles)
    begin
        @(negedge clk);
        n++;
    end
    if (!irq_req)
    begin
        $display("no interrupt request within %0d cycles at time %0t", max_cycles, $time);
        errors++;
    end
    else
    begin
        check_val("irq_code_o", 32'(irq_code), code);
    end
endtask

task automatic apply_row(input row_t r);
    case (r.op)
        OP_WR:
        begin
            @(posedge clk);
            drive_req(1'b1, r.addr, r.data, r.be);
            @(posedge clk);
            host_req <= '0;
        end
        OP_RD:
        begin
            @(posedge clk);
            drive_req(1'b0, r.addr, 0, 4'hf);
            @(negedge clk);
            check_val("host_resp_o.resp", 32'(host_resp.resp), 32'h0);
            @(posedge clk);
            host_req <= '0;
            @(negedge clk);
            check_val("host_resp_o.resp", 32'(host_resp.resp), 32'h1);
            check_val("host_resp_o.rdata", host_resp.rdata, r.exp);
        end
        OP_RD2:
        begin
            @(posedge clk);
            drive_req(1'b0, r.addr, 0, 4'hf);
            @(posedge clk);
            drive_req(1'b0, r.data, 0, 4'hf);
            @(negedge clk);
            check_val("host_resp_o.resp", 32'(host_resp.resp), 32'h1);
            check_val("host_resp_o.rdata", host_resp.rdata, r.exp);
            @(posedge clk);
            host_req <= '0;
            @(negedge clk);
            check_val("host_resp_o.resp", 32'(host_resp.resp), 32'h1);
            check_val("host_resp_o.rdata", host_resp.rdata, r.exp2);
        end
        OP_IRQ:
        begin
            @(posedge clk);
            irq <= irq_vec_t'(r.data);
        end
        OP_ACK:
        begin
            @(negedge clk);
            check_val("irq_req_o", 32'(irq_req), 32'h1);
            check_val("irq_code_o", 32'(irq_code), r.exp);
            @(posedge clk);
            irq_ack <= 1'b1;
            @(posedge clk);
            irq_ack <= 1'b0;
            @(negedge clk);
        end
        OP_WAIT:
        begin
            wait_irq(int'(r.data), r.exp);
        end
        default:
        begin
            @(posedge clk);
            @(negedge clk);
            check_val("irq_req_o", 32'(irq_req), 32'h0);
        end
    endcase
endtask

`endif

// ==== testbench/tb_sigma_tile.sv ====
// testbench for the sigma tile driving a table of host and interrupt operations
module tb_sigma_tile import tile_bus_pkg::*, tile_irq_pkg::*;
();

    localparam int CORENUM = 5;
    localparam int TMR_P   = 5;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_RD2, OP_IRQ, OP_ACK, OP_WAIT, OP_NOIRQ} op_e;

    // one table row; data holds the second address of a read pair
    typedef struct packed {
        op_e        op;
        logic [2:0] tst;
        addr_t      addr;
        word_t      data;
        be_t        be;
        word_t      exp;
        word_t      exp2;
    } row_t;

    logic       clk;
    logic       arst_n;
    host_req_t  host_req;
    host_resp_t host_resp;
    irq_vec_t   irq;
    logic       irq_ack;
    logic       irq_req;
    irq_code_t  irq_code;

    row_t  rows[$];
    word_t ram_model [1024];
    int    errors;
    int    checks;
    int    cycles;
    int    cycle_limit = 100000;

    `include "tb_tile_tasks.svh"

    sigma_tile #(
        .CORENUM(CORENUM)
    ) uut (
        .clk_i        (clk)
        , .arst_n_i   (arst_n)
        , .host_req_i (host_req)
        , .host_resp_o(host_resp)
        , .irq_i      (irq)
        , .irq_ack_i  (irq_ack)
        , .irq_req_o  (irq_req)
        , .irq_code_o (irq_code)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("run timed out after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    function void build_table();
        word_t d;
        for (int i = 0; i < 8; i++)
        begin
            d = $urandom;
            record_write(1, addr_t'(i * 4), d, 4'hf);
        end
        record_write(1, 32'h0000_0ffc, $urandom, 4'hf);
        record_write(1, 32'h0000_0004, $urandom, 4'h1);
        record_write(1, 32'h0000_0008, $urandom, 4'h6);
        record_write(1, 32'h0000_000c, $urandom, 4'h8);
        // index wraps at the RAM depth
        record_write(1, 32'h0000_1010, $urandom, 4'hc);
        for (int i = 0; i < 8; i++)
        begin
            expect_read(1, addr_t'(i * 4), mword(addr_t'(i * 4)));
        end
        expect_read(1, 32'h0000_0ffc, mword(32'h0000_0ffc));
        expect_pair(1, 32'h4, mword(32'h4), 32'h8, mword(32'h8));
        expect_pair(1, 32'hffc, mword(32'hffc), 32'h0, mword(32'h0));

        // register values left by the hard reset
        expect_read(2, 32'h0010_0004, 32'h0);
        expect_read(2, 32'h0010_0008, 32'h0);
        expect_read(2, 32'h0010_0010, 32'h0);
        expect_read(2, 32'h0010_0014, 32'h0);
        expect_read(2, 32'h0010_0000, CORENUM);
        record_write(2, 32'h0010_0008, 32'h0000_1234, 4'hf);
        expect_read(2, 32'h0010_0008, 32'h0000_1234);
        record_write(2, 32'h0010_0010, 32'h000a_bcd0, 4'hf);
        expect_read(2, 32'h0010_0010, 32'h000a_bcd0);
        expect_read(2, 32'h0010_000c, 32'h0);
        expect_read(2, 32'h0010_0018, 32'h0);
        expect_read(2, 32'h0010_001c, 32'h0);
        expect_pair(2, 32'h8, mword(32'h8), 32'h0010_0000, CORENUM);
        expect_read(2, 32'h0000_0010, mword(32'h10));
        record_write(2, 32'h0010_0008, 32'h0, 4'hf);
        record_write(2, 32'h0010_0010, 32'h0, 4'hf);

        record_write(3, 32'h0010_0008, 32'h0000_0088, 4'hf);
        push_row(OP_IRQ, 3, 0, 32'h0000_008c, 0, 0, 0);
        push_row(OP_WAIT, 3, 0, 4, 0, 3, 0);
        push_row(OP_ACK, 3, 0, 0, 0, 3, 0);
        push_row(OP_WAIT, 3, 0, 2, 0, 7, 0);
        push_row(OP_ACK, 3, 0, 0, 0, 7, 0);
        push_row(OP_NOIRQ, 3, 0, 0, 0, 0, 0);
        push_row(OP_IRQ, 3, 0, 0, 0, 0, 0);
        push_row(OP_NOIRQ, 3, 0, 0, 0, 0, 0);

        record_write(4, 32'h0010_0008, 32'h0000_0200, 4'hf);
        record_write(4, 32'h0010_000c, 32'h0000_0009, 4'hf);
        push_row(OP_WAIT, 4, 0, 4, 0, 9, 0);
        push_row(OP_ACK, 4, 0, 0, 0, 9, 0);
        push_row(OP_NOIRQ, 4, 0, 0, 0, 0, 0);
        expect_read(4, 32'h0010_000c, 32'h0);

        record_write(5, 32'h0010_0008, 32'h0000_0002, 4'hf);
        record_write(5, 32'h0010_0010, TMR_P, 4'hf);
        record_write(5, 32'h0010_0014, 32'h1, 4'hf);
        push_row(OP_WAIT, 5, 0, TMR_P + 4, 0, 1, 0);
        expect_read(5, 32'h0010_0014, 32'h1);
        record_write(5, 32'h0010_0014, 32'h0, 4'hf);
        push_row(OP_ACK, 5, 0, 0, 0, 1, 0);
        push_row(OP_NOIRQ, 5, 0, 0, 0, 0, 0);

        record_write(6, 32'h0010_0008, 32'h0000_0020, 4'hf);
        push_row(OP_IRQ, 6, 0, 32'h0000_0020, 0, 0, 0);
        push_row(OP_WAIT, 6, 0, 4, 0, 5, 0);
        record_write(6, 32'h0010_0004, 32'h1, 4'hf);
        push_row(OP_NOIRQ, 6, 0, 0, 0, 0, 0);
        expect_read(6, 32'h0010_0004, 32'h1);
        expect_read(6, 32'h0010_0008, 32'h0000_0020);
        expect_read(6, 32'h0000_0014, mword(32'h14));
        push_row(OP_IRQ, 6, 0, 0, 0, 0, 0);
        record_write(6, 32'h0010_0004, 32'h0, 4'hf);
        push_row(OP_NOIRQ, 6, 0, 0, 0, 0, 0);
        push_row(OP_IRQ, 6, 0, 32'h0000_0020, 0, 0, 0);
        push_row(OP_WAIT, 6, 0, 4, 0, 5, 0);
        push_row(OP_ACK, 6, 0, 0, 0, 5, 0);
        push_row(OP_NOIRQ, 6, 0, 0, 0, 0, 0);
        push_row(OP_IRQ, 6, 0, 0, 0, 0, 0);
    endfunction

    initial
    begin
        int   err_base;
        int   n_tests;
        logic [2:0] cur;
        host_req = '0;
        irq      = '0;
        irq_ack  = 1'b0;
        arst_n   = 1'b0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        n_tests  = 0;
        void'($urandom(77915));
        build_table();
        cycle_limit = rows.size() * 40 + TMR_P + 4;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_val("irq_req_o", 32'(irq_req), 32'h0);
        check_val("host_resp_o.resp", 32'(host_resp.resp), 32'h0);
        cur      = rows[0].tst;
        err_base = errors;
        foreach (rows[i])
        begin
            if (rows[i].tst != cur)
            begin
                report_test(cur, errors - err_base);
                n_tests++;
                cur      = rows[i].tst;
                err_base = errors;
            end
            apply_row(rows[i]);
        end
        report_test(cur, errors - err_base);
        n_tests++;
        $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
        if (errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
